// ==== hdl/cdr_defs.svh ====
`ifndef CDR_DEFS_SVH
`define CDR_DEFS_SVH

// sample side
`define N_ADC   8       // adc code width
`define N_TI    16      // interleaved samples per batch
`define N_GRP   4       // clock groups, sample 4k+g is group g
`define N_PD    12      // group phase error, +/-1024 plus offset

// loop side
`define N_INT   20      // integrator width
`define N_PHS   16      // phase accumulator width
`define N_PI    8       // interpolator code, top bits of phase
`define N_SHIFT 4       // gain shift count width
`define N_ACQ   16      // acquisition length counter width

`endif

// ==== hdl/adc_pack.sv ====
`include "cdr_defs.svh"

// types for the adc/detector side of the loop
package adc_pack;

    // raw adc sample, -128..+127
    typedef logic signed [`N_ADC-1:0] code_t;

    // summed mm error of one clock group
    typedef logic signed [`N_PD-1:0] pd_t;

    // static skew trim, one per group
    typedef logic signed [`N_ADC-1:0] offset_t;

endpackage

// ==== hdl/cdr_pack.sv ====
`include "cdr_defs.svh"

// types for the filter/control side of the loop
package cdr_pack;

    typedef logic [`N_SHIFT-1:0] shift_t;        // gain as right shift
    typedef logic signed [`N_INT-1:0] integ_t;   // integral path
    typedef logic [`N_PHS-1:0] phase_t;          // wraps modulo 2^N_PHS
    typedef logic [`N_PI-1:0] pi_code_t;         // msbs of phase_t
    typedef logic [`N_ACQ-1:0] acq_len_t;        // acq duration, cycles

    // loop sequencing
    typedef enum logic [1:0] {
        CDR_IDLE  = 2'd0,   // filters parked
        CDR_ACQ   = 2'd1,   // fast gains
        CDR_TRACK = 2'd2,   // slow gains
        CDR_HOLD  = 2'd3    // frozen
    } cdr_state_e;

endpackage

// ==== hdl/mm_pd.sv ====
`timescale 1ns/1ps
`include "cdr_defs.svh"

// mueller-muller phase detector giving one error per clock group
module mm_pd (
    input  logic              clk,
    input  logic              ext_rstb,
    input  adc_pack::code_t   codes [`N_TI-1:0],        // one batch per clk
    input  logic [`N_TI-1:0]  bits,                     // sliced decisions
    input  adc_pack::offset_t pd_offset [`N_GRP-1:0],   // per-group trim
    output adc_pack::pd_t     pd_out [`N_GRP-1:0]       // valid every cycle
);

    // worst case |sum| plus worst case |offset|
    localparam int PD_LIM = (`N_TI / `N_GRP) * 2 * (2 ** (`N_ADC - 1)) + 2 ** (`N_ADC - 1);

    // pre holds the newest batch
    adc_pack::code_t codes_pre [`N_TI-1:0];   // batch n+1
    adc_pack::code_t codes_cur [`N_TI-1:0];   // batch n under evaluation
    // decisions keep all three batches for the boundary symbols
    logic [`N_TI-1:0] bits_pre;
    logic [`N_TI-1:0] bits_cur;
    logic [`N_TI-1:0] bits_pos;

    logic signed [1:0] ak [`N_TI:-1];             // +/-1 symbol signs with both edges
    logic signed [2:0] ak_dif [`N_TI-1:0];        // a[i+1] - a[i-1] in -2/0/+2
    logic signed [`N_ADC+1:0] term [`N_TI-1:0];   // per-sample mm term within +/-256
    logic signed [`N_PD-1:0] grp_sum [`N_GRP-1:0];

    // all zero after reset so every bit reads as -1
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            codes_pre <= '{default: '0};
            codes_cur <= '{default: '0};
            bits_pre  <= '0;
            bits_cur  <= '0;
            bits_pos  <= '0;
        end else begin
            codes_pre <= codes;
            codes_cur <= codes_pre;
            bits_pre  <= bits;
            bits_cur  <= bits_pre;
            bits_pos  <= bits_cur;
        end
    end

    // boundary symbols come from the neighbouring batches
    assign ak[`N_TI] = bits_pre[0] ? 2'sd1 : -2'sd1;          // first of next batch
    assign ak[-1]    = bits_pos[`N_TI-1] ? 2'sd1 : -2'sd1;    // last of prev batch

    for (genvar i = 0; i < `N_TI; i++) begin : g_sym
        assign ak[i] = bits_cur[i] ? 2'sd1 : -2'sd1;
    end

    // code times neighbour sign difference
    for (genvar i = 0; i < `N_TI; i++) begin : g_term
        assign ak_dif[i] = ak[i+1] - ak[i-1];
        assign term[i]   = codes_cur[i] * ak_dif[i];   // 10b signed context
    end

    // group g gathers samples g, g+4, g+8, g+12
    always_comb begin
        for (int g = 0; g < `N_GRP; g++) begin
            grp_sum[g] = '0;
            for (int k = 0; k < `N_TI / `N_GRP; k++) begin
                grp_sum[g] = grp_sum[g] + term[`N_GRP*k + g];
            end
        end
    end

    // offset added to the full-width sum without rescale
    for (genvar g = 0; g < `N_GRP; g++) begin : g_out
        assign pd_out[g] = grp_sum[g] + pd_offset[g];

        // error never leaves the detector's headroom
        a_pd_range: assert property (@(posedge clk) disable iff (!ext_rstb)
            (pd_out[g] <= PD_LIM) && (pd_out[g] >= -PD_LIM))
            else $error("mm_pd: group %0d error %0d out of range", g, pd_out[g]);
    end

endmodule

// ==== hdl/loop_filter.sv ====
`timescale 1ns/1ps
`include "cdr_defs.svh"

// second-order pi filter for one clock group
// saturating integrator feeding a wrapping phase accumulator
module loop_filter (
    input  logic               clk,
    input  logic               ext_rstb,
    input  adc_pack::pd_t      pd_in,      // group phase error
    input  logic               lf_en,      // update this edge
    input  logic               lf_clear,   // zero integ and phase
    input  cdr_pack::shift_t   kp_shift,   // proportional gain
    input  cdr_pack::shift_t   ki_shift,   // integral gain
    output cdr_pack::pi_code_t pi_code     // to interpolator
);

    cdr_pack::integ_t integ;               // integral state
    cdr_pack::phase_t phase;               // wraps, never saturates
    cdr_pack::integ_t pd_ext;              // error at integrator width
    logic signed [`N_INT:0] integ_sum;     // one guard bit
    cdr_pack::integ_t integ_sat;
    cdr_pack::integ_t p_term;
    cdr_pack::integ_t i_term;
    logic signed [`N_INT:0] step;          // phase increment before wrap
    cdr_pack::phase_t phase_nxt;

    assign pd_ext = pd_in;   // sign extends

    // integrator update, clamp on overflow
    assign integ_sum = integ + pd_ext;
    assign integ_sat = (integ_sum[`N_INT] != integ_sum[`N_INT-1]) ?
                       {integ_sum[`N_INT], {(`N_INT-1){~integ_sum[`N_INT]}}} :
                       integ_sum[`N_INT-1:0];

    // gains as arithmetic shifts; integral path uses the old integ
    assign p_term = pd_ext >>> kp_shift;
    assign i_term = integ >>> ki_shift;
    assign step   = p_term + i_term;

    // only the low bits matter modulo 2^N_PHS
    assign phase_nxt = phase + step[`N_PHS-1:0];

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            integ <= '0;
            phase <= '0;
        end else if (lf_clear) begin
            integ <= '0;     // fresh acquisition
            phase <= '0;
        end else if (lf_en) begin
            integ <= integ_sat;
            phase <= phase_nxt;
        end
        // neither -> hold
    end

    // code lags phase by one clk
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            pi_code <= '0;
        end else begin
            pi_code <= phase[`N_PHS-1 -: `N_PI];
        end
    end

    // clear and update come from the controller and must never overlap
    a_en_clr_excl: assert property (@(posedge clk) disable iff (!ext_rstb)
        !(lf_en && lf_clear))
        else $error("loop_filter: lf_en and lf_clear high together");

endmodule

// ==== hdl/cdr_ctrl.sv ====
`timescale 1ns/1ps
`include "cdr_defs.svh"

// sequences idle -> acq -> track, with hold on freeze
module cdr_ctrl (
    input  logic               clk,
    input  logic               ext_rstb,
    input  logic               cdr_en,     // low parks the loop
    input  logic               freeze,     // stop filter updates
    input  cdr_pack::acq_len_t acq_len,    // enabled cycles of acq
    input  cdr_pack::shift_t   kp_acq,
    input  cdr_pack::shift_t   ki_acq,
    input  cdr_pack::shift_t   kp_trk,
    input  cdr_pack::shift_t   ki_trk,
    output logic               lf_en,
    output logic               lf_clear,   // one cycle, first acq cycle
    output cdr_pack::shift_t   kp_shift,
    output cdr_pack::shift_t   ki_shift,
    output logic               tracking
);

    cdr_pack::cdr_state_e state;
    cdr_pack::cdr_state_e state_nxt;
    cdr_pack::acq_len_t   acq_cnt;     // enabled acq cycles so far
    logic [`N_ACQ:0]      cnt_inc;     // count incl. this cycle, no wrap
    logic                 acq_last;    // this enabled cycle ends acq

    assign cnt_inc  = {1'b0, acq_cnt} + 1'b1;
    assign acq_last = (cnt_inc >= {1'b0, acq_len});   // zero length acts as one

    always_comb begin
        state_nxt = state;
        if (!cdr_en) begin
            state_nxt = cdr_pack::CDR_IDLE;    // from anywhere
        end else begin
            case (state)
                cdr_pack::CDR_IDLE: begin
                    state_nxt = cdr_pack::CDR_ACQ;
                end
                cdr_pack::CDR_ACQ: begin
                    if (freeze)
                        state_nxt = cdr_pack::CDR_HOLD;
                    else if (lf_en && acq_last)
                        state_nxt = cdr_pack::CDR_TRACK;
                end
                cdr_pack::CDR_TRACK: begin
                    if (freeze)
                        state_nxt = cdr_pack::CDR_HOLD;
                end
                cdr_pack::CDR_HOLD: begin
                    if (!freeze)
                        state_nxt = cdr_pack::CDR_TRACK;   // never back to acq
                end
                default: state_nxt = cdr_pack::CDR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            state    <= cdr_pack::CDR_IDLE;
            lf_clear <= 1'b0;
            acq_cnt  <= '0;
        end else begin
            state    <= state_nxt;
            lf_clear <= (state == cdr_pack::CDR_IDLE) && cdr_en;   // entering acq
            if (state == cdr_pack::CDR_IDLE)
                acq_cnt <= '0;
            else if ((state == cdr_pack::CDR_ACQ) && lf_en)
                acq_cnt <= cnt_inc[`N_ACQ-1:0];
        end
    end

    // decoded outputs, clear cycle masks the update
    assign lf_en    = ((state == cdr_pack::CDR_ACQ) || (state == cdr_pack::CDR_TRACK))
                      && !lf_clear;
    assign kp_shift = (state == cdr_pack::CDR_ACQ) ? kp_acq : kp_trk;
    assign ki_shift = (state == cdr_pack::CDR_ACQ) ? ki_acq : ki_trk;
    assign tracking = (state == cdr_pack::CDR_TRACK);

    // catches x or corrupted state bits
    a_state_legal: assert property (@(posedge clk) disable iff (!ext_rstb)
        state inside {cdr_pack::CDR_IDLE, cdr_pack::CDR_ACQ,
                      cdr_pack::CDR_TRACK, cdr_pack::CDR_HOLD})
        else $error("cdr_ctrl: illegal state %b", state);

endmodule

// ==== hdl/cdr_core.sv ====
`timescale 1ns/1ps
`include "cdr_defs.svh"

// clock recovery top: detector, controller, one filter per clock group
module cdr_core (
    input  logic               clk,
    input  logic               ext_rstb,
    input  adc_pack::code_t    codes [`N_TI-1:0],        // adc batch
    input  logic [`N_TI-1:0]   bits,                     // decisions
    input  adc_pack::offset_t  pd_offset [`N_GRP-1:0],   // per-group trim
    input  logic               cdr_en,
    input  logic               freeze,
    input  cdr_pack::acq_len_t acq_len,
    input  cdr_pack::shift_t   kp_acq,                   // fast gains
    input  cdr_pack::shift_t   ki_acq,
    input  cdr_pack::shift_t   kp_trk,                   // slow gains
    input  cdr_pack::shift_t   ki_trk,
    output adc_pack::pd_t      pd_out [`N_GRP-1:0],      // also feeds filters
    output cdr_pack::pi_code_t pi_code [`N_GRP-1:0],     // one per group
    output logic               tracking
);

    // shared by all four filters
    logic             lf_en;
    logic             lf_clear;
    cdr_pack::shift_t kp_shift;
    cdr_pack::shift_t ki_shift;

    mm_pd u_pd (
        .clk       (clk),
        .ext_rstb  (ext_rstb),
        .codes     (codes),
        .bits      (bits),
        .pd_offset (pd_offset),
        .pd_out    (pd_out)
    );

    cdr_ctrl u_ctrl (
        .clk      (clk),
        .ext_rstb (ext_rstb),
        .cdr_en   (cdr_en),
        .freeze   (freeze),
        .acq_len  (acq_len),
        .kp_acq   (kp_acq),
        .ki_acq   (ki_acq),
        .kp_trk   (kp_trk),
        .ki_trk   (ki_trk),
        .lf_en    (lf_en),
        .lf_clear (lf_clear),
        .kp_shift (kp_shift),
        .ki_shift (ki_shift),
        .tracking (tracking)
    );

    // filter g closes the loop for clock group g
    for (genvar g = 0; g < `N_GRP; g++) begin : g_lf
        loop_filter u_lf (
            .clk      (clk),
            .ext_rstb (ext_rstb),
            .pd_in    (pd_out[g]),
            .lf_en    (lf_en),
            .lf_clear (lf_clear),
            .kp_shift (kp_shift),
            .ki_shift (ki_shift),
            .pi_code  (pi_code[g])
        );
    end

endmodule

// ==== tb/cdr_model.svh ====
`ifndef CDR_MODEL_SVH
`define CDR_MODEL_SVH

// loop reference stepped once per clk from the tb input regs
int m_code_pre [`N_TI];              // newest batch
int m_code_cur [`N_TI];              // batch under evaluation
bit [`N_TI-1:0] m_bits_pre;
bit [`N_TI-1:0] m_bits_cur;
bit [`N_TI-1:0] m_bits_pos;
int m_integ [`N_GRP];
int m_phase [`N_GRP];                // kept in 0 .. 2^N_PHS-1
int m_pi [`N_GRP];
cdr_pack::cdr_state_e m_state;
bit m_clear;                         // clear pulse seen by filters
int m_acq_cnt;
bit m_sat_seen;                      // integrator hit a rail
bit m_wrap_seen;                     // phase crossed 0 or 2^N_PHS

localparam int INTEG_MAX = (1 << (`N_INT - 1)) - 1;
localparam int INTEG_MIN = -(1 << (`N_INT - 1));
localparam int PHASE_MOD = 1 << `N_PHS;

function automatic int sym(input bit b);
    return b ? 1 : -1;               // decision to +/-1
endfunction

// mm error of group g on the middle batch plus its trim
function automatic int model_pd(input int g);
    int sum;
    int i;
    int a_nxt;
    int a_prv;
    sum = 0;
    for (int k = 0; k < `N_TI / `N_GRP; k++) begin
        i = `N_GRP * k + g;
        a_nxt = (i == `N_TI - 1) ? sym(m_bits_pre[0]) : sym(m_bits_cur[i + 1]);
        a_prv = (i == 0) ? sym(m_bits_pos[`N_TI - 1]) : sym(m_bits_cur[i - 1]);
        sum += m_code_cur[i] * (a_nxt - a_prv);
    end
    return sum + int'(pd_offset[g]);
endfunction

task automatic model_reset();
    for (int i = 0; i < `N_TI; i++) begin
        m_code_pre[i] = 0;
        m_code_cur[i] = 0;
    end
    m_bits_pre = '0;                 // zeros read as -1 symbols
    m_bits_cur = '0;
    m_bits_pos = '0;
    for (int g = 0; g < `N_GRP; g++) begin
        m_integ[g] = 0;
        m_phase[g] = 0;
        m_pi[g]    = 0;
    end
    m_state     = cdr_pack::CDR_IDLE;
    m_clear     = 1'b0;
    m_acq_cnt   = 0;
    m_sat_seen  = 1'b0;
    m_wrap_seen = 1'b0;
endtask

// one rising edge with the inputs the DUT samples there
task automatic model_step();
    int pd;
    int isum;
    int ph;
    int kp;
    int ki;
    bit en;
    en = (m_state == cdr_pack::CDR_ACQ || m_state == cdr_pack::CDR_TRACK) && !m_clear;
    kp = (m_state == cdr_pack::CDR_ACQ) ? int'(kp_acq) : int'(kp_trk);
    ki = (m_state == cdr_pack::CDR_ACQ) ? int'(ki_acq) : int'(ki_trk);
    for (int g = 0; g < `N_GRP; g++) begin
        pd = model_pd(g);
        m_pi[g] = m_phase[g] >> (`N_PHS - `N_PI);     // from the old phase
        if (m_clear) begin
            m_integ[g] = 0;
            m_phase[g] = 0;
        end else if (en) begin
            ph   = m_phase[g] + (pd >>> kp) + (m_integ[g] >>> ki);
            isum = m_integ[g] + pd;
            if (isum > INTEG_MAX || isum < INTEG_MIN)
                m_sat_seen = 1'b1;
            m_integ[g] = (isum > INTEG_MAX) ? INTEG_MAX :
                         (isum < INTEG_MIN) ? INTEG_MIN : isum;
            if (ph < 0 || ph >= PHASE_MOD)
                m_wrap_seen = 1'b1;
            m_phase[g] = ph & (PHASE_MOD - 1);
        end
    end
    // acq counter advances only on enabled acq cycles
    if (m_state == cdr_pack::CDR_IDLE)
        m_acq_cnt = 0;
    else if (m_state == cdr_pack::CDR_ACQ && en)
        m_acq_cnt++;
    m_clear = (m_state == cdr_pack::CDR_IDLE) && cdr_en;
    if (!cdr_en)
        m_state = cdr_pack::CDR_IDLE;
    else if (m_state == cdr_pack::CDR_IDLE)
        m_state = cdr_pack::CDR_ACQ;
    else if (m_state != cdr_pack::CDR_HOLD && freeze)
        m_state = cdr_pack::CDR_HOLD;
    else if (m_state == cdr_pack::CDR_HOLD && !freeze)
        m_state = cdr_pack::CDR_TRACK;
    else if (m_state == cdr_pack::CDR_ACQ && en && m_acq_cnt >= int'(acq_len))
        m_state = cdr_pack::CDR_TRACK;
    // batch window shifts
    for (int i = 0; i < `N_TI; i++) begin
        m_code_cur[i] = m_code_pre[i];
        m_code_pre[i] = int'(codes[i]);
    end
    m_bits_pos = m_bits_cur;
    m_bits_cur = m_bits_pre;
    m_bits_pre = bits;
endtask

`endif

// ==== tb/cdr_core_tb.sv ====
`timescale 1ns/1ps
`include "cdr_defs.svh"

module cdr_core_tb;

    localparam int IDLE_LEN  = 20;
    localparam int ACQ_EXTRA = 40;     // tracking cycles after acq
    localparam int FRZ_LEN   = 30;
    localparam int SAT_LEN   = 700;    // integrator reaches its rail well before this

    logic               clk;
    logic               ext_rstb;
    adc_pack::code_t    codes [`N_TI-1:0];
    logic [`N_TI-1:0]   bits;
    adc_pack::offset_t  pd_offset [`N_GRP-1:0];
    logic               cdr_en;
    logic               freeze;
    cdr_pack::acq_len_t acq_len;
    cdr_pack::shift_t   kp_acq;
    cdr_pack::shift_t   ki_acq;
    cdr_pack::shift_t   kp_trk;
    cdr_pack::shift_t   ki_trk;
    adc_pack::pd_t      pd_out [`N_GRP-1:0];
    cdr_pack::pi_code_t pi_code [`N_GRP-1:0];
    logic               tracking;

    integer             seed;
    int                 err_pd;
    int                 err_pi;
    int                 err_trk;
    int                 err_misc;
    int                 cycle_cnt;
    int                 cycle_limit;
    cdr_pack::pi_code_t pi_snap [`N_GRP];

    `include "cdr_model.svh"

    cdr_core DUT (
        .clk       (clk),
        .ext_rstb  (ext_rstb),
        .codes     (codes),
        .bits      (bits),
        .pd_offset (pd_offset),
        .cdr_en    (cdr_en),
        .freeze    (freeze),
        .acq_len   (acq_len),
        .kp_acq    (kp_acq),
        .ki_acq    (ki_acq),
        .kp_trk    (kp_trk),
        .ki_trk    (ki_trk),
        .pd_out    (pd_out),
        .pi_code   (pi_code),
        .tracking  (tracking)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run length is known once acq_len is drawn
    initial begin
        cycle_cnt = 0;
        wait (cycle_limit > 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Test FAILED");
        $finish;
    end

    task automatic check_pd(input adc_pack::pd_t got, input adc_pack::pd_t exp, input int g);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: pd_out[%0d] is %0d, expected %0d",
                     $time, g, got, exp);
            err_pd++;
        end
    endtask

    task automatic check_pi(input cdr_pack::pi_code_t got, input cdr_pack::pi_code_t exp,
                            input int g);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: pi_code[%0d] is %0d, expected %0d",
                     $time, g, got, exp);
            err_pi++;
        end
    endtask

    task automatic check_trk(input bit got, input bit exp);
        if (got != exp) begin
            $display("CHECK FAILED at %0t: tracking is %0b, expected %0b", $time, got, exp);
            err_trk++;
        end
    endtask

    task automatic drive_random();
        for (int i = 0; i < `N_TI; i++)
            codes[i] <= $random(seed);
        bits <= $random(seed);
        for (int g = 0; g < `N_GRP; g++)
            pd_offset[g] <= $random(seed);
    endtask

    // symbols -,-,+,+ per four samples: neighbour difference is +2 at i%4 of 1 and 2,
    // else -2, so each code takes the matching rail and every term adds
    task automatic drive_max();
        for (int i = 0; i < `N_TI; i++)
            codes[i] <= (i % 4 == 1 || i % 4 == 2) ? 8'sd127 : -8'sd128;
        bits <= 16'hcccc;
        for (int g = 0; g < `N_GRP; g++)
            pd_offset[g] <= 8'sd127;
    endtask

    // drive at the rising edge, compare and step the model at the falling edge
    task automatic run_cycles(input int n, input bit en, input bit frz, input bit max_codes);
        repeat (n) begin
            @(posedge clk);
            cdr_en <= en;
            freeze <= frz;
            if (max_codes)
                drive_max();
            else
                drive_random();
            @(negedge clk);
            for (int g = 0; g < `N_GRP; g++) begin
                check_pd(pd_out[g], adc_pack::pd_t'(model_pd(g)), g);
                check_pi(pi_code[g], cdr_pack::pi_code_t'(m_pi[g]), g);
            end
            check_trk(tracking, m_state == cdr_pack::CDR_TRACK);
            model_step();
        end
    endtask

    task automatic take_snapshot();
        for (int g = 0; g < `N_GRP; g++)
            pi_snap[g] = pi_code[g];
    endtask

    task automatic check_held();
        for (int g = 0; g < `N_GRP; g++)
            check_pi(pi_code[g], pi_snap[g], g);
    endtask

    initial begin
        seed      = 32'hf56c5e11;
        ext_rstb  = 1'b0;
        cdr_en    = 1'b0;
        freeze    = 1'b0;
        bits      = '0;
        for (int i = 0; i < `N_TI; i++)
            codes[i] = '0;
        for (int g = 0; g < `N_GRP; g++)
            pd_offset[g] = $random(seed);
        acq_len   = cdr_pack::acq_len_t'(20 + {$random(seed)} % 32);
        kp_acq    = 4'd2;
        ki_acq    = 4'd6;
        kp_trk    = 4'd5;
        ki_trk    = 4'd11;
        err_pd    = 0;
        err_pi    = 0;
        err_trk   = 0;
        err_misc  = 0;
        cycle_limit = 3 + 2 * IDLE_LEN + 2 * (int'(acq_len) + ACQ_EXTRA) + 2 * FRZ_LEN
                      + SAT_LEN + 100;
        model_reset();
        repeat (2) @(posedge clk);
        ext_rstb <= 1'b1;
        @(negedge clk);
        // pipeline still empty, error is the trim alone
        for (int g = 0; g < `N_GRP; g++) begin
            check_pd(pd_out[g], pd_offset[g], g);
            check_pi(pi_code[g], '0, g);
        end
        check_trk(tracking, 1'b0);
        model_step();

        run_cycles(IDLE_LEN, 1'b0, 1'b0, 1'b0);               // detector alone
        run_cycles(int'(acq_len) + ACQ_EXTRA, 1'b1, 1'b0, 1'b0);
        check_trk(tracking, 1'b1);
        run_cycles(4, 1'b1, 1'b1, 1'b0);                      // last update drains
        take_snapshot();
        run_cycles(FRZ_LEN - 4, 1'b1, 1'b1, 1'b0);
        check_held();
        check_trk(tracking, 1'b0);
        run_cycles(FRZ_LEN, 1'b1, 1'b0, 1'b0);
        check_trk(tracking, 1'b1);
        run_cycles(SAT_LEN, 1'b1, 1'b0, 1'b1);
        if (!m_sat_seen || !m_wrap_seen) begin
            $display("saturation run did not reach the integrator rail and a phase wrap");
            err_misc++;
        end
        run_cycles(4, 1'b0, 1'b0, 1'b0);                      // back to idle
        take_snapshot();
        run_cycles(IDLE_LEN - 4, 1'b0, 1'b0, 1'b0);
        check_held();
        run_cycles(4, 1'b1, 1'b0, 1'b0);                      // clear lands here
        for (int g = 0; g < `N_GRP; g++)
            check_pi(pi_code[g], '0, g);
        run_cycles(int'(acq_len) + ACQ_EXTRA - 4, 1'b1, 1'b0, 1'b0);
        check_trk(tracking, 1'b1);

        $display("errors: pd %0d, pi %0d, tracking %0d, other %0d",
                 err_pd, err_pi, err_trk, err_misc);
        if (err_pd + err_pi + err_trk + err_misc == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// ==== cdr_core.f ====
+incdir+hdl
+incdir+tb
hdl/adc_pack.sv
hdl/cdr_pack.sv
hdl/mm_pd.sv
hdl/loop_filter.sv
hdl/cdr_ctrl.sv
hdl/cdr_core.sv
tb/cdr_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cdr_core_tb
FILELIST  ?= cdr_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= Test OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
